/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := s16_sdram_map_tb
FILELIST  := s16_sdram_map.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* hdl/s16_dwnld.sv */
module s16_dwnld (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             downloading,
    input  logic [s16_mem_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                       ioctl_data,
    input  logic                             ioctl_wr,
    output logic [s16_mem_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] prog_data,
    output logic [1:0]                       prog_mask,
    output logic [1:0]                       prog_ba,
    output logic                             prog_we,
    input  logic                             prog_ack,
    output logic                             dwnld_busy,
    output logic [7:0]                       game_id,
    output logic                             dec_en,
    output logic                             dec_type
);
    import s16_mem_pkg::*;

    logic                byte_wr;
    logic                header;
    logic                pair_end;
    logic [IOCTL_AW-1:0] data_pos;   // Byte offset past the header
    logic [IOCTL_AW-1:0] ba1_pos;    // Byte offset inside bank 1
    logic [7:0]          hi_byte;

    assign byte_wr  = downloading && ioctl_wr;
    assign header   = ioctl_addr < HEADER_LEN;
    assign data_pos = ioctl_addr - HEADER_LEN;
    assign ba1_pos  = data_pos - BA1_START;
    assign pair_end = byte_wr && !header && data_pos[0];

    assign prog_mask  = 2'b00;                  // Active low, full word
    assign dwnld_busy = downloading | prog_we;

    // Game configuration captured from the header bytes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_id  <= '0;
            dec_en   <= 1'b0;
            dec_type <= 1'b0;
        end else if (byte_wr && header) begin
            if (ioctl_addr == GAME_ID_POS) begin
                game_id <= ioctl_data;
            end
            if (ioctl_addr == DEC_POS) begin
                dec_en   <= |ioctl_data[1:0];  // Either key type enables it
                dec_type <= ioctl_data[1];
            end
        end
    end

    // Word request, held until the controller takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (pair_end) begin
            prog_we <= 1'b1;
        end else if (prog_ack) begin
            prog_we <= 1'b0;
        end
    end

    // Byte packing and bank routing
    always_ff @(posedge clk) begin
        if (byte_wr && !header && !data_pos[0]) begin
            hi_byte <= ioctl_data;               // Even byte goes high
        end
        if (pair_end) begin
            prog_data <= {hi_byte, ioctl_data};
            if (data_pos >= BA1_START) begin
                prog_ba   <= 2'd1;
                prog_addr <= ba1_pos[SDRAM_AW:1];
            end else begin
                prog_ba   <= 2'd0;
                prog_addr <= data_pos[SDRAM_AW:1];
            end
        end
    end

    // Host byte spacing must cover the controller's ack latency
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        byte_wr |-> !prog_we)
        else $error("ioctl_wr arrived with an unacknowledged word");

endmodule

/* hdl/s16_mem_pkg.sv */
package s16_mem_pkg;

    // Bus widths
    localparam int IOCTL_AW = 25;   // Download byte address
    localparam int SDRAM_AW = 22;   // Bank word address
    localparam int SDRAM_DW = 16;
    localparam int RAM_AW   = 14;   // 16k words of work RAM
    localparam int CHAR_AW  = 12;
    localparam int SCR_AW   = 14;

    // ROM image header layout, byte offsets from the start of the image
    localparam logic [IOCTL_AW-1:0] HEADER_LEN  = 25'd32;
    localparam logic [IOCTL_AW-1:0] GAME_ID_POS = 25'h18;
    localparam logic [IOCTL_AW-1:0] DEC_POS     = 25'h10;

    // Byte offset past the header where bank 1 data begins
    localparam logic [IOCTL_AW-1:0] BA1_START   = 25'h10;

    // Bank 0 word map
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET  = 22'h20_0000;

    // Bank 1 word map, one region per graphics slot
    localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = 22'h00_0000;  // 4k words
    localparam logic [SDRAM_AW-1:0] SCR1_OFFSET = 22'h00_1000;  // 16k words
    localparam logic [SDRAM_AW-1:0] SCR2_OFFSET = 22'h00_5000;  // 16k words

    // One data word, seen whole or byte by byte
    typedef union packed {
        logic [SDRAM_DW-1:0] w;
        logic [1:0][7:0]     b;     // b[1] is the upper byte
    } s16_word_u;

endpackage

/* hdl/s16_ram_slot.sv */
module s16_ram_slot (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             ram_cs,
    input  logic [s16_mem_pkg::RAM_AW-1:0]   ram_addr,
    input  logic                             ram_rnw,
    input  logic [1:0]                       ram_dsn,
    input  logic [s16_mem_pkg::SDRAM_DW-1:0] ram_dout,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] ram_data,
    output logic                             ram_ok,
    output logic [s16_mem_pkg::SDRAM_AW-1:0] ba0_addr,
    output logic                             ba0_rd,
    output logic                             ba0_wr,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] ba0_din,
    output logic [1:0]                       ba0_din_m,
    input  logic                             ba0_ack,
    input  logic                             ba0_rdy,
    input  logic [s16_mem_pkg::SDRAM_DW-1:0] data_read
);
    import s16_mem_pkg::*;

    logic [RAM_AW-1:0] last_addr;
    logic              last_rnw;
    logic              active;    // last_addr/last_rnw describe the live access
    logic              waiting;   // Acked, rdy still to come
    logic              busy;
    logic              same_acc;
    logic              new_acc;
    logic              start;
    logic              done;
    s16_word_u         data_q;
    s16_word_u         wr_word;
    s16_word_u         merged;

    assign same_acc = active && ram_addr == last_addr && ram_rnw == last_rnw;
    assign new_acc  = ram_cs && !same_acc;
    assign busy     = ba0_rd | ba0_wr | waiting;
    assign start    = new_acc && !busy;
    assign done     = ba0_rdy && waiting;
    assign ram_data = data_q.w;

    // Written bytes replace their lanes in the held word
    always_comb begin
        wr_word.w = ba0_din;
        merged    = data_q;
        if (!ba0_din_m[1]) begin
            merged.b[1] = wr_word.b[1];
        end
        if (!ba0_din_m[0]) begin
            merged.b[0] = wr_word.b[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ba0_rd    <= 1'b0;
            ba0_wr    <= 1'b0;
            waiting   <= 1'b0;
            active    <= 1'b0;
            ram_ok    <= 1'b0;
            last_addr <= '0;
            last_rnw  <= 1'b1;
        end else begin
            if (!ram_cs) begin
                active <= 1'b0;
                ram_ok <= 1'b0;
            end else if (new_acc) begin
                ram_ok <= 1'b0;
            end
            if (start) begin
                active    <= 1'b1;
                last_addr <= ram_addr;
                last_rnw  <= ram_rnw;
                ba0_rd    <= ram_rnw;
                ba0_wr    <= !ram_rnw;
            end
            if (ba0_ack && (ba0_rd || ba0_wr)) begin
                ba0_rd  <= 1'b0;
                ba0_wr  <= 1'b0;
                waiting <= 1'b1;
            end
            if (done) begin
                waiting <= 1'b0;
                ram_ok  <= ram_cs && same_acc;  // Stale if the CPU moved on
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ba0_addr  <= RAM_OFFSET + SDRAM_AW'(ram_addr);
            ba0_din   <= ram_dout;
            ba0_din_m <= ram_rnw ? 2'b11 : ram_dsn;
        end
        if (done) begin
            if (last_rnw) begin
                data_q.w <= data_read;
            end else begin
                data_q <= merged;
            end
        end
    end

    // Controller answers only a request it has acknowledged
    a_rdy_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        ba0_rdy |-> waiting)
        else $error("bank 0 rdy without an acknowledged request");

endmodule

/* hdl/s16_rom_slots.sv */
module s16_rom_slots (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             lvbl,
    input  logic [8:0]                       vrender,
    input  logic [s16_mem_pkg::CHAR_AW-1:0]  char_addr,
    input  logic [s16_mem_pkg::SCR_AW-1:0]   scr1_addr,
    input  logic [s16_mem_pkg::SCR_AW-1:0]   scr2_addr,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] char_data,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] scr1_data,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] scr2_data,
    output logic                             char_ok,
    output logic                             scr1_ok,
    output logic                             scr2_ok,
    output logic [s16_mem_pkg::SDRAM_AW-1:0] ba1_addr,
    output logic                             ba1_rd,
    input  logic                             ba1_ack,
    input  logic                             ba1_rdy,
    input  logic [s16_mem_pkg::SDRAM_DW-1:0] data_read
);
    import s16_mem_pkg::*;

    logic                gfx_cs;
    logic [SDRAM_AW-1:0] req_addr   [3];
    logic [SDRAM_AW-1:0] cache_addr [3];
    logic [SDRAM_DW-1:0] cache_data [3];
    logic [2:0]          cache_vld;
    logic [2:0]          hit;
    logic [2:0]          miss;
    logic [2:0]          ok_q;
    logic [1:0]          sel;
    logic [1:0]          owner;       // Slot that holds the bank request
    logic                waiting;
    logic                idle;
    logic                issue;
    logic                done;

    // Fetch window: active video, first line, or lines past 255
    assign gfx_cs = lvbl || vrender == 9'd0 || vrender[8];

    assign req_addr[0] = CHAR_OFFSET + SDRAM_AW'(char_addr);
    assign req_addr[1] = SCR1_OFFSET + SDRAM_AW'(scr1_addr);
    assign req_addr[2] = SCR2_OFFSET + SDRAM_AW'(scr2_addr);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            hit[i]  = cache_vld[i] && cache_addr[i] == req_addr[i];
            miss[i] = gfx_cs && !hit[i];
        end
    end

    // Lowest index wins
    always_comb begin
        sel = 2'd0;
        for (int i = 2; i >= 0; i--) begin
            if (miss[i]) begin
                sel = 2'(i);
            end
        end
    end

    assign idle  = !ba1_rd && !waiting;
    assign issue = idle && |miss;
    assign done  = waiting && ba1_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ba1_rd    <= 1'b0;
            waiting   <= 1'b0;
            owner     <= 2'd0;
            cache_vld <= 3'b000;
            ok_q      <= 3'b000;
        end else begin
            ok_q <= {3{gfx_cs}} & hit;
            if (issue) begin
                ba1_rd <= 1'b1;
                owner  <= sel;
            end
            if (ba1_rd && ba1_ack) begin
                ba1_rd  <= 1'b0;
                waiting <= 1'b1;
            end
            if (done) begin
                waiting          <= 1'b0;
                cache_vld[owner] <= 1'b1;
                // Answer now rather than wait for the hit next cycle
                ok_q[owner]      <= gfx_cs && req_addr[owner] == ba1_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ba1_addr <= req_addr[sel];
        end
        if (done) begin
            cache_addr[owner] <= ba1_addr;
            cache_data[owner] <= data_read;
        end
    end

    assign char_data = cache_data[0];
    assign scr1_data = cache_data[1];
    assign scr2_data = cache_data[2];
    assign char_ok   = ok_q[0];
    assign scr1_ok   = ok_q[1];
    assign scr2_ok   = ok_q[2];

    // Request and address are held until the controller takes them
    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ba1_rd && !ba1_ack |=> ba1_rd && $stable(ba1_addr))
        else $error("ba1_rd dropped or moved before ack");

endmodule

/* hdl/s16_sdram_map.sv */
module s16_sdram_map (
    input  logic                             clk,
    input  logic                             rst_n,

    // ROM download
    input  logic                             downloading,
    input  logic [s16_mem_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                       ioctl_data,
    input  logic                             ioctl_wr,
    output logic [s16_mem_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] prog_data,
    output logic [1:0]                       prog_mask,
    output logic [1:0]                       prog_ba,
    output logic                             prog_we,
    input  logic                             prog_ack,
    output logic                             dwnld_busy,
    output logic [7:0]                       game_id,
    output logic                             dec_en,
    output logic                             dec_type,

    // Main CPU work RAM
    input  logic                             ram_cs,
    input  logic [s16_mem_pkg::RAM_AW-1:0]   ram_addr,
    input  logic                             ram_rnw,
    input  logic [1:0]                       ram_dsn,
    input  logic [s16_mem_pkg::SDRAM_DW-1:0] ram_dout,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] ram_data,
    output logic                             ram_ok,

    // Video timing and graphics ROMs
    input  logic                             lvbl,
    input  logic [8:0]                       vrender,
    input  logic [s16_mem_pkg::CHAR_AW-1:0]  char_addr,
    input  logic [s16_mem_pkg::SCR_AW-1:0]   scr1_addr,
    input  logic [s16_mem_pkg::SCR_AW-1:0]   scr2_addr,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] char_data,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] scr1_data,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] scr2_data,
    output logic                             char_ok,
    output logic                             scr1_ok,
    output logic                             scr2_ok,

    // Bank 0, read/write
    output logic [s16_mem_pkg::SDRAM_AW-1:0] ba0_addr,
    output logic                             ba0_rd,
    output logic                             ba0_wr,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] ba0_din,
    output logic [1:0]                       ba0_din_m,  // Active low
    input  logic                             ba0_ack,
    input  logic                             ba0_rdy,

    // Bank 1, read only
    output logic [s16_mem_pkg::SDRAM_AW-1:0] ba1_addr,
    output logic                             ba1_rd,
    input  logic                             ba1_ack,
    input  logic                             ba1_rdy,

    input  logic [s16_mem_pkg::SDRAM_DW-1:0] data_read   // Shared by both banks
);

    s16_dwnld     u_dwnld (.*);
    s16_ram_slot  u_ram   (.*);
    s16_rom_slots u_rom   (.*);

endmodule

/* s16_sdram_map.f */
hdl/s16_mem_pkg.sv
hdl/s16_dwnld.sv
hdl/s16_ram_slot.sv
hdl/s16_rom_slots.sv
hdl/s16_sdram_map.sv
tb/tb_clk_gen.sv
tb/tb_sdram_model.sv
tb/s16_sdram_map_tb.sv

/* tb/s16_sdram_map_tb.sv */
module s16_sdram_map_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import s16_mem_pkg::*;

    localparam int MAX_CYCLES = 20000;
    localparam int IMG_LEN    = 72;     // 32 header bytes, 8 words bank 0, 12 words bank 1
    localparam int NRAM       = 8;

    logic                clk, rst_n;
    logic                downloading, ioctl_wr, prog_we, prog_ack, dwnld_busy;
    logic [IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]          ioctl_data, game_id;
    logic                dec_en, dec_type;
    logic [SDRAM_AW-1:0] prog_addr, ba0_addr, ba1_addr;
    logic [SDRAM_DW-1:0] prog_data, ram_dout, ram_data, ba0_din, data_read;
    logic [SDRAM_DW-1:0] char_data, scr1_data, scr2_data;
    logic [1:0]          prog_mask, prog_ba, ram_dsn, ba0_din_m;
    logic                ram_cs, ram_rnw, ram_ok, lvbl;
    logic [RAM_AW-1:0]   ram_addr;
    logic [8:0]          vrender;
    logic [CHAR_AW-1:0]  char_addr;
    logic [SCR_AW-1:0]   scr1_addr, scr2_addr;
    logic                char_ok, scr1_ok, scr2_ok;
    logic                ba0_rd, ba0_wr, ba0_ack, ba0_rdy, ba1_rd, ba1_ack, ba1_rdy;

    logic [31:0]         rnd_state;
    logic [31:0]         dly_state = 32'd58;   // Feeds the controller delays
    int                  cycles = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  tests = 0;
    int                  err_mark = 0;
    logic [7:0]          image [IMG_LEN];
    logic [SDRAM_DW-1:0] exp_ba1 [int unsigned];  // Bank 1 words as downloaded
    logic [RAM_AW-1:0]   ram_pick [NRAM];
    logic [SDRAM_DW-1:0] ram_exp [NRAM];

    s16_sdram_map  u_dut (.*);
    tb_sdram_model u_mem (.*, .rnd(dly_state[7:0]));
    tb_clk_gen     u_clk (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    function automatic logic [SDRAM_DW-1:0] merge_bytes(input logic [SDRAM_DW-1:0] old_w,
                                                        input logic [SDRAM_DW-1:0] new_w,
                                                        input logic [1:0]          dsn);
        s16_word_u o;
        s16_word_u n;
        o.w = old_w;
        n.w = new_w;
        if (!dsn[1]) o.b[1] = n.b[1];
        if (!dsn[0]) o.b[0] = n.b[0];
        return o.w;
    endfunction

    // Bank 1 word as loaded, else the controller's address pattern
    function automatic logic [SDRAM_DW-1:0] rom_word(input logic [SDRAM_AW-1:0] a);
        if (exp_ba1.exists(a)) return exp_ba1[a];
        return 16'(a) ^ 16'(a >> 6) ^ 16'h3c5a;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s done, %0d errors", num, name, errors - err_mark);
        err_mark = errors;
        tests++;
    endtask

    // One CPU access, ends once ram_ok is seen
    task automatic ram_access(input int idx, input logic rnw, input logic [1:0] dsn,
                              input logic [SDRAM_DW-1:0] d);
        ram_cs = 1'b0;
        @(negedge clk);
        ram_cs   = 1'b1;
        ram_addr = ram_pick[idx];
        ram_rnw  = rnw;
        ram_dsn  = dsn;
        ram_dout = d;
        @(negedge clk);
        while (!ram_ok) @(negedge clk);
        if (rnw) begin
            check_eq(ram_data, ram_exp[idx], $sformatf("ram read at %0h", ram_pick[idx]));
        end else begin
            ram_exp[idx] = merge_bytes(ram_exp[idx], d, dsn);
        end
    endtask

    always @(negedge clk) dly_state <= xorshift(dly_state);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int                  i;
        int                  mode;
        logic                ba;
        logic [SDRAM_DW-1:0] word;
        logic [SDRAM_AW-1:0] waddr;
        logic [IOCTL_AW-1:0] pos;
        logic [2:0]          seen;
        logic [CHAR_AW-1:0]  last_char;
        logic [SCR_AW-1:0]   last_scr1, last_scr2;
        rnd_state   = 32'd58;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ram_cs      = 1'b0;
        ram_addr    = '0;
        ram_rnw     = 1'b1;
        ram_dsn     = 2'b11;
        ram_dout    = '0;
        lvbl        = 1'b0;      // Start outside the fetch window
        vrender     = 9'd1;
        char_addr   = '0;
        scr1_addr   = '0;
        scr2_addr   = '0;
        @(posedge rst_n);
        @(negedge clk);
        check_eq({char_ok, scr1_ok, scr2_ok, ram_ok, prog_we, ba0_rd, ba0_wr, ba1_rd, dec_en},
                 0, "outputs after reset");
        finish_test(1, "reset");

        for (i = 0; i < IMG_LEN; i++) image[i] = 8'(next_rand());
        downloading = 1'b1;
        for (i = 0; i < IMG_LEN; i++) begin
            ioctl_addr = IOCTL_AW'(i);
            ioctl_data = image[i];
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr   = 1'b0;
            if (i >= HEADER_LEN && i[0]) begin
                pos   = IOCTL_AW'(i) - HEADER_LEN - 1;   // Even byte of the pair
                word  = {image[i-1], image[i]};
                ba    = pos >= BA1_START;
                waddr = ba ? SDRAM_AW'((pos - BA1_START) >> 1) : SDRAM_AW'(pos >> 1);
                if (ba) exp_ba1[waddr] = word;
                while (!prog_we) @(negedge clk);
                if (i == IMG_LEN - 1) downloading = 1'b0;   // Last word still pending
                check_eq(prog_data, word, "prog_data");
                check_eq(prog_ba, {1'b0, ba}, "prog_ba");
                check_eq(prog_addr, waddr, "prog_addr");
                check_eq(prog_mask, 2'b00, "prog_mask");
                while (prog_we) begin
                    check_eq(dwnld_busy, 1'b1, "dwnld_busy with a word pending");
                    @(negedge clk);
                end
            end
            repeat (8) @(negedge clk);
            if (i == HEADER_LEN - 1) begin
                check_eq(game_id, image[GAME_ID_POS], "game_id");
                check_eq(dec_en, |image[DEC_POS][1:0], "dec_en");
                check_eq(dec_type, image[DEC_POS][1], "dec_type");
                finish_test(2, "header");
            end
        end
        check_eq(dwnld_busy, 1'b0, "dwnld_busy after download");
        finish_test(3, "download words");

        // Distinct work RAM words, each first written whole
        for (i = 0; i < NRAM; i++) begin
            ram_pick[i] = RAM_AW'({next_rand(), 3'(i)});
            ram_exp[i]  = '0;
            ram_access(i, 1'b0, 2'b00, 16'(next_rand()));
        end
        repeat (24) begin
            i    = int'(next_rand() % NRAM);
            mode = int'(next_rand() % 4);
            ram_access(i, 1'b0, 2'(mode), 16'(next_rand()));
        end
        for (i = 0; i < NRAM; i++) ram_access(i, 1'b1, 2'b11, '0);
        ram_cs = 1'b0;
        finish_test(4, "work ram");

        repeat (20) begin
            mode    = int'(next_rand() % 3);
            lvbl    = mode == 0;
            vrender = (mode == 1) ? 9'd0 : 9'(256 + next_rand() % 256);
            char_addr = CHAR_AW'(next_rand() % 16);   // Mostly downloaded words
            scr1_addr = SCR_AW'(next_rand() % 32);
            scr2_addr = SCR_AW'(next_rand() % 32);
            seen = 3'b000;
            @(negedge clk);
            while (seen != 3'b111) begin
                if (char_ok && !seen[0])
                    check_eq(char_data, rom_word(CHAR_OFFSET + SDRAM_AW'(char_addr)), "char data");
                if (scr1_ok && !seen[1])
                    check_eq(scr1_data, rom_word(SCR1_OFFSET + SDRAM_AW'(scr1_addr)), "scr1 data");
                if (scr2_ok && !seen[2])
                    check_eq(scr2_data, rom_word(SCR2_OFFSET + SDRAM_AW'(scr2_addr)), "scr2 data");
                seen |= {scr2_ok, scr1_ok, char_ok};
                @(negedge clk);
            end
        end
        last_char = char_addr;
        last_scr1 = scr1_addr;
        last_scr2 = scr2_addr;
        lvbl      = 1'b0;
        vrender   = 9'(1 + next_rand() % 255);
        char_addr = CHAR_AW'(next_rand());
        scr1_addr = SCR_AW'(next_rand());
        scr2_addr = SCR_AW'(next_rand());
        repeat (20) begin
            @(negedge clk);
            check_eq(ba1_rd, 1'b0, "ba1_rd outside the fetch window");
        end
        finish_test(5, "graphics reads");

        char_addr = last_char;
        scr1_addr = last_scr1;
        scr2_addr = last_scr2;
        @(negedge clk);
        check_eq({char_ok, scr1_ok, scr2_ok}, 3'b000, "ok outside the fetch window");
        lvbl = 1'b1;
        @(negedge clk);
        check_eq({char_ok, scr1_ok, scr2_ok}, 3'b111, "ok on repeated addresses");
        check_eq(char_data, rom_word(CHAR_OFFSET + SDRAM_AW'(last_char)), "cached char data");
        check_eq(scr1_data, rom_word(SCR1_OFFSET + SDRAM_AW'(last_scr1)), "cached scr1 data");
        check_eq(scr2_data, rom_word(SCR2_OFFSET + SDRAM_AW'(last_scr2)), "cached scr2 data");
        repeat (5) begin
            check_eq(ba1_rd, 1'b0, "ba1_rd on a cache hit");
            @(negedge clk);
        end
        finish_test(6, "cache hits");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);             // Release away from the active edge
        rst_n = 1'b1;
    end

    always #5 clk = ~clk;           // 10 ns period

endmodule

/* tb/tb_sdram_model.sv */
module tb_sdram_model (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [7:0]                       rnd,        // Fresh random bits each cycle
    input  logic [s16_mem_pkg::SDRAM_AW-1:0] prog_addr,
    input  logic [s16_mem_pkg::SDRAM_DW-1:0] prog_data,
    input  logic [1:0]                       prog_mask,
    input  logic [1:0]                       prog_ba,
    input  logic                             prog_we,
    output logic                             prog_ack,
    input  logic [s16_mem_pkg::SDRAM_AW-1:0] ba0_addr,
    input  logic                             ba0_rd,
    input  logic                             ba0_wr,
    input  logic [s16_mem_pkg::SDRAM_DW-1:0] ba0_din,
    input  logic [1:0]                       ba0_din_m,
    output logic                             ba0_ack,
    output logic                             ba0_rdy,
    input  logic [s16_mem_pkg::SDRAM_AW-1:0] ba1_addr,
    input  logic                             ba1_rd,
    output logic                             ba1_ack,
    output logic                             ba1_rdy,
    output logic [s16_mem_pkg::SDRAM_DW-1:0] data_read
);
    timeunit 1ns;
    timeprecision 1ps;
    import s16_mem_pkg::*;

    logic [SDRAM_DW-1:0] bank0 [int unsigned];
    logic [SDRAM_DW-1:0] bank1 [int unsigned];
    logic [1:0]          state;     // 0 idle, 1 ack delay, 2 data delay
    logic [1:0]          src;       // 0 download, 1 bank 0, 2 bank 1
    logic [2:0]          cnt;
    logic [SDRAM_AW-1:0] addr_q;

    // Unwritten words read back as a pattern of their address
    function automatic logic [SDRAM_DW-1:0] read_bank(input logic ba, input logic [SDRAM_AW-1:0] a);
        if (!ba && bank0.exists(a)) return bank0[a];
        if (ba && bank1.exists(a)) return bank1[a];
        return 16'(a) ^ 16'(a >> 6) ^ 16'h3c5a;
    endfunction

    function automatic logic [SDRAM_DW-1:0] merge_word(input logic [SDRAM_DW-1:0] old_w,
                                                       input logic [SDRAM_DW-1:0] new_w,
                                                       input logic [1:0]          mask);
        s16_word_u o;
        s16_word_u n;
        o.w = old_w;
        n.w = new_w;
        if (!mask[1]) o.b[1] = n.b[1];   // Mask is active low
        if (!mask[0]) o.b[0] = n.b[0];
        return o.w;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= 2'd0;
            src       <= 2'd0;
            cnt       <= 3'd0;
            addr_q    <= '0;
            prog_ack  <= 1'b0;
            ba0_ack   <= 1'b0;
            ba1_ack   <= 1'b0;
            ba0_rdy   <= 1'b0;
            ba1_rdy   <= 1'b0;
            data_read <= '0;
        end else begin
            prog_ack <= 1'b0;
            ba0_ack  <= 1'b0;
            ba1_ack  <= 1'b0;
            ba0_rdy  <= 1'b0;
            ba1_rdy  <= 1'b0;
            case (state)
                2'd0: begin
                    cnt <= 3'(rnd % 3);             // Ack 1 to 3 cycles on
                    if (prog_we) begin
                        src   <= 2'd0;
                        state <= 2'd1;
                    end else if (ba0_rd || ba0_wr) begin
                        src   <= 2'd1;
                        state <= 2'd1;
                    end else if (ba1_rd) begin
                        src   <= 2'd2;
                        state <= 2'd1;
                    end
                end
                2'd1: begin
                    if (cnt != 3'd0) begin
                        cnt <= cnt - 3'd1;
                    end else begin
                        state <= 2'd2;
                        cnt   <= (src == 2'd0) ? 3'd0 : 3'(1 + rnd[3:2]);
                        if (src == 2'd0) begin
                            prog_ack <= 1'b1;
                            if (prog_ba[0]) begin
                                bank1[prog_addr] = merge_word(read_bank(1'b1, prog_addr),
                                                              prog_data, prog_mask);
                            end else begin
                                bank0[prog_addr] = merge_word(read_bank(1'b0, prog_addr),
                                                              prog_data, prog_mask);
                            end
                        end else if (src == 2'd1) begin
                            ba0_ack <= 1'b1;
                            addr_q  <= ba0_addr;
                            if (ba0_wr) begin
                                bank0[ba0_addr] = merge_word(read_bank(1'b0, ba0_addr),
                                                             ba0_din, ba0_din_m);
                            end
                        end else begin
                            ba1_ack <= 1'b1;
                            addr_q  <= ba1_addr;
                        end
                    end
                end
                default: begin
                    if (cnt != 3'd0) begin
                        cnt <= cnt - 3'd1;
                    end else begin
                        state <= 2'd0;
                        if (src == 2'd1) begin
                            ba0_rdy   <= 1'b1;
                            data_read <= read_bank(1'b0, addr_q);
                        end else if (src == 2'd2) begin
                            ba1_rdy   <= 1'b1;
                            data_read <= read_bank(1'b1, addr_q);
                        end
                    end
                end
            endcase
        end
    end

endmodule
